//--- hdl/conv_encoder.sv
`timescale 1ns/10ps

module conv_encoder #(
    parameter int K    = 7,
    parameter int RATE = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_mode_sel,     // level, encode or table
    input  logic                  i_bit_valid,    // one-cycle strobe for i_bit
    input  logic                  i_bit,
    input  logic                  i_clear,        // zero the shift register
    input  logic                  i_table_start,  // kick off a table scan
    input  conv_pkg::gen_poly_t   i_gen_poly,
    input  logic                  i_full,         // FIFO cannot take another write
    output logic                  o_wr_en,
    output conv_pkg::fifo_entry_t o_entry
);
    import conv_pkg::*;

    localparam int STATE_W = K - 1;   // encoder memory
    localparam int SCAN_W  = K + 1;   // state bits on top of two pair bits

    logic [STATE_W-1:0]  state_q;     // encode shift register, newest bit at lsb
    logic [SCAN_W-1:0]   scan_cnt;    // {state, pair}, pair steps fastest
    logic                scan_active; // scan started and not yet finished
    logic [STATE_W-1:0]  scan_state;
    logic [1:0]          scan_pair;
    logic                scan_last;   // final state and pair combination
    logic                start_ok;    // start pulse taken this cycle
    logic                scan_go;     // a branch entry goes out this cycle
    logic                bit_ok;      // an info bit is taken this cycle
    logic [MAX_RATE-1:0] enc_sym;
    logic [MAX_RATE-1:0] first_sym;
    logic [MAX_RATE-1:0] second_sym;
    fifo_entry_t         next_entry;

    // parity of the window under each polynomial, only low K taps count
    function automatic logic [MAX_RATE-1:0] parity(
        input gen_poly_t  poly,
        input logic [K-1:0] window
    );
        logic [MAX_RATE-1:0] code;
        code = '0;  // bits at RATE and above stay zero
        for (int i = 0; i < RATE; i++)
        begin
            code[i] = ^(poly[i][K-1:0] & window);
        end
        return code;
    endfunction

    assign scan_state = scan_cnt[SCAN_W-1:2];
    assign scan_pair  = scan_cnt[1:0];
    assign scan_last  = &scan_cnt;  // all ones = last state, pair 3

    assign start_ok = i_table_start && (i_mode_sel == MODE_TABLE) && !scan_active;
    assign scan_go  = (start_ok || scan_active) && !i_full;  // holds while full
    assign bit_ok   = i_bit_valid && (i_mode_sel == MODE_ENCODE) && !scan_active
                      && !i_full;  // strobes while full are dropped

    assign enc_sym    = parity(i_gen_poly, {state_q, i_bit});
    assign first_sym  = parity(i_gen_poly, {scan_state, scan_pair[0]});
    assign second_sym = parity(i_gen_poly, {scan_state[STATE_W-2:0], scan_pair[0],
                                            scan_pair[1]});  // state after bit 0

    always_comb
    begin
        next_entry = '0;
        if (scan_go)
        begin
            next_entry.is_branch                 = 1'b1;
            next_entry.last                      = scan_last;
            next_entry.payload.branch.pair       = scan_pair;
            next_entry.payload.branch.state      = MAX_STATE_W'(scan_state);
            next_entry.payload.branch.second_sym = second_sym;
            next_entry.payload.branch.first_sym  = first_sym;
        end
        else
        begin
            next_entry.payload.sym.bits = enc_sym;  // spare bits left at zero
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q     <= '0;
            scan_cnt    <= '0;
            scan_active <= 1'b0;
            o_wr_en     <= 1'b0;
        end
        else
        begin
            o_wr_en <= scan_go || bit_ok;  // write lands one clock after the decision
            if (i_clear)
            begin
                state_q <= '0;
            end
            else if (bit_ok)
            begin
                state_q <= {state_q[STATE_W-2:0], i_bit};  // low K-1 bits of window
            end
            if (scan_go)
            begin
                scan_cnt    <= scan_cnt + 1'b1;  // wraps to zero after the last entry
                scan_active <= !scan_last;
            end
            else if (start_ok)
            begin
                scan_active <= 1'b1;  // FIFO full at start, first entry waits
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (scan_go || bit_ok)
        begin
            o_entry <= next_entry;
        end
    end

endmodule

//--- hdl/conv_encoder_top.sv
`timescale 1ns/10ps

module conv_encoder_top #(
    parameter int K     = 7,
    parameter int RATE  = 2,
    parameter int DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_mode_sel,
    input  logic                i_bit_valid,
    input  logic                i_bit,
    input  logic                i_clear,
    input  logic                i_table_start,
    input  conv_pkg::gen_poly_t i_gen_poly,
    output logic                o_full,       // source stops strobing while high
    output logic                o_code_bit,
    output logic                o_code_valid,
    output conv_pkg::branch_t   o_branch,
    output logic                o_branch_valid,
    output logic                o_table_done
);
    import conv_pkg::*;

    logic        wr_en;       // encoder to FIFO
    fifo_entry_t wr_entry;
    logic        rd_en;       // serializer pop
    fifo_entry_t head_entry;
    logic        fifo_empty;

    conv_encoder #(.K(K), .RATE(RATE)) conv_encoder_inst (
        .clk(clk), .rst(rst),
        .i_mode_sel(i_mode_sel), .i_bit_valid(i_bit_valid), .i_bit(i_bit),
        .i_clear(i_clear), .i_table_start(i_table_start), .i_gen_poly(i_gen_poly),
        .i_full(o_full),  // same level the source watches
        .o_wr_en(wr_en), .o_entry(wr_entry)
    );

    entry_fifo #(.DEPTH(DEPTH)) entry_fifo_inst (
        .clk(clk), .rst(rst),
        .i_wr_en(wr_en), .i_entry(wr_entry), .i_rd_en(rd_en),
        .o_entry(head_entry), .o_full(o_full), .o_empty(fifo_empty)
    );

    symbol_serializer #(.RATE(RATE)) symbol_serializer_inst (
        .clk(clk), .rst(rst),
        .i_empty(fifo_empty), .i_entry(head_entry), .o_rd_en(rd_en),
        .o_code_bit(o_code_bit), .o_code_valid(o_code_valid),
        .o_branch(o_branch), .o_branch_valid(o_branch_valid),
        .o_table_done(o_table_done)
    );

endmodule

//--- hdl/conv_pkg.sv
package conv_pkg;

    localparam int MAX_K       = 9;   // longest constraint length
    localparam int MAX_RATE    = 3;   // most code bits per info bit
    localparam int MAX_STATE_W = 8;   // MAX_K - 1 state bits

    localparam logic MODE_ENCODE = 1'b0;  // one code symbol per strobed bit
    localparam logic MODE_TABLE  = 1'b1;  // radix-4 branch table scan

    // polynomial i masks the window for output bit i
    typedef logic [MAX_RATE-1:0][MAX_K-1:0] gen_poly_t;

    typedef struct packed {
        logic [12:0]         spare;   // always zero
        logic [MAX_RATE-1:0] bits;    // output bit i at position i
    } code_sym_t;

    // same layout as the decoder's mux word
    typedef struct packed {
        logic [1:0]             pair;        // radix-4 input pair
        logic [MAX_STATE_W-1:0] state;       // zero-extended from K-1 bits
        logic [MAX_RATE-1:0]    second_sym;  // second step of the pair
        logic [MAX_RATE-1:0]    first_sym;   // first step of the pair
    } branch_t;

    // one FIFO word, read as a code symbol or as a branch entry
    typedef union packed {
        code_sym_t sym;
        branch_t   branch;
    } entry_payload_u;

    typedef struct packed {
        logic           is_branch;  // selects the union view
        logic           last;       // final entry of a table scan
        entry_payload_u payload;
    } fifo_entry_t;

endpackage

//--- hdl/entry_fifo.sv
`timescale 1ns/10ps

module entry_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_wr_en,
    input  conv_pkg::fifo_entry_t i_entry,
    input  logic                  i_rd_en,   // pops the head on this edge
    output conv_pkg::fifo_entry_t o_entry,   // head, valid while not empty
    output logic                  o_full,
    output logic                  o_empty
);
    import conv_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fifo_entry_t      mem [DEPTH];  // entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // entries held
    logic             do_wr;
    logic             do_rd;

    // circular step, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr = i_wr_en && (count != CNT_W'(DEPTH));  // never overwrite
    assign do_rd = i_rd_en && (count != '0);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_wr) mem[wr_ptr] <= i_entry;
    end

    assign o_entry = mem[rd_ptr];  // fall-through read, written entry visible next cycle
    assign o_empty = (count == '0);
    // one slot early, the producer's registered write is still in flight
    assign o_full  = (count >= CNT_W'(DEPTH - 1));

endmodule

//--- hdl/symbol_serializer.sv
`timescale 1ns/10ps

module symbol_serializer #(
    parameter int RATE = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_empty,
    input  conv_pkg::fifo_entry_t i_entry,       // FIFO head
    output logic                  o_rd_en,       // one-cycle pop
    output logic                  o_code_bit,
    output logic                  o_code_valid,
    output conv_pkg::branch_t     o_branch,
    output logic                  o_branch_valid,
    output logic                  o_table_done   // with the last branch entry
);
    import conv_pkg::*;

    localparam int CNT_W = $clog2(MAX_RATE + 1);

    logic [RATE-1:0]  shift_q;     // code bits, msb goes out first
    logic [CNT_W-1:0] bit_cnt;     // code bits still to send
    logic             idle;        // free to take the next entry
    logic             pop_sym;
    logic             pop_branch;
    code_sym_t        head_sym;    // head seen as a code symbol

    assign head_sym = i_entry.payload.sym;

    // the last bit of a symbol overlaps the next pop, so the stream has no gaps
    assign idle       = (bit_cnt <= CNT_W'(1));
    assign o_rd_en    = idle && !i_empty;
    assign pop_branch = o_rd_en && i_entry.is_branch;
    assign pop_sym    = o_rd_en && !i_entry.is_branch;

    assign o_code_valid = (bit_cnt != '0);
    assign o_code_bit   = shift_q[RATE-1];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            bit_cnt        <= '0;
            o_branch_valid <= 1'b0;
            o_table_done   <= 1'b0;
        end
        else
        begin
            o_branch_valid <= pop_branch;  // one cycle, the cycle after the pop
            o_table_done   <= pop_branch && i_entry.last;
            if (pop_sym)
            begin
                bit_cnt <= CNT_W'(RATE);
            end
            else if (bit_cnt != '0)
            begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop_sym)
        begin
            shift_q <= head_sym.bits[RATE-1:0];  // bit RATE-1 leads
        end
        else if (o_code_valid)
        begin
            shift_q <= shift_q << 1;
        end
        if (pop_branch)
        begin
            o_branch <= i_entry.payload.branch;  // whole entry, no reshaping
        end
    end

endmodule

//--- sources.f
hdl/conv_pkg.sv
hdl/conv_encoder.sv
hdl/entry_fifo.sv
hdl/symbol_serializer.sv
hdl/conv_encoder_top.sv
tb/conv_encoder_tb.sv

//--- tb/conv_encoder_tb.sv
`timescale 1ns/10ps

module conv_encoder_tb;
    import conv_pkg::*;

    localparam int K           = 5;
    localparam int RATE        = 3;
    localparam int DEPTH       = 8;
    localparam int TABLE_SIZE  = 4 * (2 ** (K - 1));      // entries per scan
    localparam int NUM_BITS    = 200 + 100 + 51;          // info bits over all encode tests
    localparam int DRAIN_LIMIT = 4 * DEPTH * RATE + TABLE_SIZE + 100;
    localparam longint WATCHDOG_NS = 2 * (NUM_BITS * RATE + 2 * TABLE_SIZE + 50) * 40;

    logic      clk;
    logic      rst;
    logic      i_mode_sel;
    logic      i_bit_valid;
    logic      i_bit;
    logic      i_clear;
    logic      i_table_start;
    gen_poly_t i_gen_poly;
    logic      o_full;
    logic      o_code_bit;
    logic      o_code_valid;
    branch_t   o_branch;
    logic      o_branch_valid;
    logic      o_table_done;

    logic [31:0]  lfsr_q;          // random source
    logic [31:0]  rnd;
    logic [K-2:0] model_state;     // reference encoder memory
    logic         exp_bits[$];     // serial bits still owed by the DUT
    branch_t      exp_branch[$];   // branch entries in scan order
    branch_t      exp_b;
    int           error_count;
    int           check_count;
    int           branch_seen;     // branch entries in the current scan
    int           done_count;
    int           test_start;      // error count when the test began
    logic         full_seen;

    conv_encoder_top #(.K(K), .RATE(RATE), .DEPTH(DEPTH)) conv_encoder_top_inst (
        .clk(clk), .rst(rst),
        .i_mode_sel(i_mode_sel), .i_bit_valid(i_bit_valid), .i_bit(i_bit),
        .i_clear(i_clear), .i_table_start(i_table_start), .i_gen_poly(i_gen_poly),
        .o_full(o_full), .o_code_bit(o_code_bit), .o_code_valid(o_code_valid),
        .o_branch(o_branch), .o_branch_valid(o_branch_valid), .o_table_done(o_table_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the lsb
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};  // one step per bit
        end
    endtask

    // xor of every window tap that polynomial i selects
    function automatic logic [MAX_RATE-1:0] model_code(input gen_poly_t poly,
                                                       input logic [K-1:0] window);
        logic [MAX_RATE-1:0] c;
        c = '0;
        for (int i = 0; i < RATE; i++)
        begin
            for (int j = 0; j < K; j++)
            begin
                if (poly[i][j] && window[j]) c[i] = ~c[i];
            end
        end
        return c;
    endfunction

    task automatic expect_bit(input logic b);
        logic [MAX_RATE-1:0] sym;
        sym = model_code(i_gen_poly, {model_state, b});
        for (int i = RATE - 1; i >= 0; i--)
        begin
            exp_bits.push_back(sym[i]);  // msb of the symbol goes out first
        end
        model_state = {model_state[K-3:0], b};
    endtask

    task automatic expect_table(input gen_poly_t poly);
        branch_t      b;
        logic [K-2:0] s;
        for (int st = 0; st < 2 ** (K - 1); st++)
        begin
            for (int p = 0; p < 4; p++)  // pair steps fastest
            begin
                s            = (K - 1)'(st);
                b            = '0;
                b.pair       = p[1:0];
                b.state      = MAX_STATE_W'(s);
                b.first_sym  = model_code(poly, {s, p[0]});
                b.second_sym = model_code(poly, {s[K-3:0], p[0], p[1]});
                exp_branch.push_back(b);
            end
        end
    endtask

    task automatic compare_code_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_branch(input string name, input branch_t got, input branch_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // outputs hang off registers only, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (rst === 1'b1)
        begin
            if (o_code_valid)
            begin
                if (exp_bits.size() == 0)
                begin
                    $display("error at %0t: code bit appeared with none expected", $time);
                    error_count++;
                end
                else
                begin
                    compare_code_bit("o_code_bit", o_code_bit, exp_bits.pop_front());
                end
            end
            if (o_branch_valid)
            begin
                branch_seen++;
                if (exp_branch.size() == 0)
                begin
                    $display("error at %0t: branch entry appeared with none expected", $time);
                    error_count++;
                end
                else
                begin
                    exp_b = exp_branch.pop_front();
                    compare_branch("o_branch", o_branch, exp_b);
                end
                compare_flag("o_table_done", o_table_done, branch_seen == TABLE_SIZE);
            end
            else if (o_table_done)
            begin
                compare_flag("o_table_done", o_table_done, 1'b0);  // done without an entry
            end
            if (o_table_done) done_count++;
        end
    end

    task automatic send_bit(input logic b);
        while (o_full)  // source holds off, strobe would be dropped
        begin
            full_seen = 1'b1;
            @(negedge clk);
        end
        i_bit_valid = 1'b1;
        i_bit       = b;
        expect_bit(b);
        @(negedge clk);
        i_bit_valid = 1'b0;
    endtask

    task automatic send_random(input int n, input logic with_gaps);
        for (int i = 0; i < n; i++)
        begin
            if (with_gaps)
            begin
                draw_bits(2, rnd);
                repeat (rnd[1:0]) @(negedge clk);  // 0 to 3 idle cycles
            end
            draw_bits(1, rnd);
            send_bit(rnd[0]);
        end
    endtask

    task automatic apply_poly();
        draw_bits(27, rnd);
        i_gen_poly = rnd[26:0];
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while ((exp_bits.size() != 0 || exp_branch.size() != 0) && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_bits.size() != 0 || exp_branch.size() != 0)
        begin
            $display("error at %0t: output stalled, %0d code bits and %0d branch entries missing",
                     $time, exp_bits.size(), exp_branch.size());
            error_count++;
            exp_bits.delete();
            exp_branch.delete();
        end
        repeat (4) @(negedge clk);  // stray output would show here
    endtask

    task automatic report_test(input string name);
        $display("test %-14s %0d errors", name, error_count - test_start);
    endtask

    task automatic run_table(input string name);
        test_start  = error_count;
        apply_poly();
        i_mode_sel  = MODE_TABLE;
        branch_seen = 0;
        done_count  = 0;
        expect_table(i_gen_poly);
        @(negedge clk);
        i_table_start = 1'b1;
        @(negedge clk);
        i_table_start = 1'b0;
        wait_drain(DRAIN_LIMIT);
        if (branch_seen != TABLE_SIZE)
        begin
            $display("error: scan gave %0d branch entries instead of %0d", branch_seen, TABLE_SIZE);
            error_count++;
        end
        if (done_count != 1)
        begin
            $display("error: o_table_done pulsed %0d times in one scan", done_count);
            error_count++;
        end
        i_mode_sel = MODE_ENCODE;
        report_test(name);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        rst           = 1'b0;
        i_mode_sel    = MODE_ENCODE;
        i_bit_valid   = 1'b0;
        i_bit         = 1'b0;
        i_clear       = 1'b0;
        i_table_start = 1'b0;
        i_gen_poly    = '0;
        lfsr_q        = 32'h12b5;
        model_state   = '0;
        error_count   = 0;
        check_count   = 0;
        branch_seen   = 0;
        done_count    = 0;
        full_seen     = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;

        test_start = error_count;
        @(negedge clk);
        compare_flag("o_code_valid", o_code_valid, 1'b0);
        compare_flag("o_branch_valid", o_branch_valid, 1'b0);
        compare_flag("o_table_done", o_table_done, 1'b0);
        compare_flag("o_full", o_full, 1'b0);
        report_test("reset");

        test_start = error_count;
        apply_poly();
        send_random(200, 1'b1);
        wait_drain(DRAIN_LIMIT);
        report_test("encode_random");

        test_start = error_count;
        apply_poly();
        full_seen = 1'b0;
        send_random(100, 1'b0);  // strobe every cycle the FIFO has room
        wait_drain(DRAIN_LIMIT);
        if (!full_seen)
        begin
            $display("error: o_full never rose under back-pressure");
            error_count++;
        end
        report_test("back_pressure");

        test_start = error_count;
        send_random(20, 1'b1);
        send_bit(1'b1);  // memory is nonzero when the clear arrives
        i_clear = 1'b1;
        @(negedge clk);
        i_clear     = 1'b0;
        model_state = '0;  // bits already taken keep their symbols
        send_random(30, 1'b1);
        wait_drain(DRAIN_LIMIT);
        report_test("clear");

        run_table("table_a");
        run_table("table_b");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
